/* all.f */
+incdir+.
lbist_cmd_pkg.sv
lbist_poly_pkg.sv
lbist_lfsr.sv
lbist_cut.sv
lbist_misr.sv
lbist_ctrl.sv
lbist_top.sv
tb_lbist.sv

/* Makefile */
# Verilator flow for the LBIST testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_lbist
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= TEST PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides pass or fail
sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_lbist.sv */
// ========================================
// LBIST testbench
// Random command sequences checked against a
// model of the LFSR, CUT and MISR
// ========================================

`default_nettype none

`include "lbist_settings.svh"

module tb_lbist
    import lbist_cmd_pkg::*;
    import lbist_poly_pkg::*;
();

    localparam int W       = `LBIST_WIDTH;
    localparam int TIMEOUT = 2000;

    logic          clk;
    logic          reset;
    logic          cmd_val;
    lbist_cmd_op_e cmd_op;
    logic [W-1:0]  cmd_word;
    logic          cmd_rdy;
    logic          done_val;
    logic [W-1:0]  signature;
    logic          done_rdy;

    logic [31:0]   rng_state = 32'h059d3ddf;
    logic [W-1:0]  model_seed;
    logic [W-1:0]  new_seed;
    int            n;

    lbist_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .cmd_val   (cmd_val),
        .cmd_op    (cmd_op),
        .cmd_word  (cmd_word),
        .cmd_rdy   (cmd_rdy),
        .done_val  (done_val),
        .signature (signature),
        .done_rdy  (done_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // Random numbers
    // ========================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        rng_state = xorshift32(rng_state);
        return lo + int'(rng_state % 32'(hi - lo + 1));
    endfunction

    function automatic logic [W-1:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state[W-1:0];
    endfunction

    // ========================================
    // Reference model
    // ========================================
    function automatic logic [W-1:0] lfsr_next(input logic [W-1:0] v);
        return {v[W-2:0], ^(v & lbist_tap_mask(W))};
    endfunction

    // Rotate-XOR stage, then add the bit-reversed value
    function automatic logic [W-1:0] cut_model(input logic [W-1:0] v);
        logic [W-1:0] s1;
        logic [W-1:0] rev;
        s1 = v ^ {v[W-8:0], v[W-1:W-7]};
        for (int i = 0; i < W; i++) begin
            rev[W-1-i] = s1[i];
        end
        return s1 + rev;
    endfunction

    function automatic logic [W-1:0] misr_next(input logic [W-1:0] sig, input logic [W-1:0] rsp);
        return {sig[W-2:0], ^(sig & lbist_tap_mask(W))} ^ rsp;
    endfunction

    function automatic logic [W-1:0] model_signature(input logic [W-1:0] seed, input int count);
        logic [W-1:0] v;
        logic [W-1:0] sig;
        v   = seed;
        sig = '0;
        for (int k = 0; k < count; k++) begin
            sig = misr_next(sig, cut_model(v));
            v   = lfsr_next(v);
        end
        return sig;
    endfunction

    // ========================================
    // Checking and handshakes
    // ========================================
    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic report_timeout(input string what);
        lbist_ctrl_state_e st;
        st = dut_i.ctrl_i.state;
        stop_with_failure($sformatf("Timed out waiting for %s, controller in state %s",
                                    what, st.name()));
    endtask

    // Starts right after a rising edge, ends on the edge of the transfer
    task automatic send_cmd(input lbist_cmd_op_e op, input logic [W-1:0] word);
        int t;
        cmd_val  <= 1'b1;
        cmd_op   <= op;
        cmd_word <= word;
        t = 0;
        @(negedge clk);
        while (!cmd_rdy && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!cmd_rdy) begin
            report_timeout("cmd_rdy");
        end
        @(posedge clk);
        cmd_val <= 1'b0;
    endtask

    // Waits for the result, stalls done_rdy, then takes the result
    task automatic collect_result(input int stall, output logic [W-1:0] sig);
        int t;
        t = 0;
        @(negedge clk);
        while (!done_val && t < TIMEOUT) begin
            check_value("cmd_rdy", 32'(cmd_rdy), 32'd0);
            @(negedge clk);
            t++;
        end
        if (!done_val) begin
            report_timeout("done_val");
        end
        sig = signature;
        check_value("cmd_rdy", 32'(cmd_rdy), 32'd0);
        // Result must hold while not taken
        repeat (stall) begin
            @(negedge clk);
            check_value("done_val", 32'(done_val), 32'd1);
            check_value("signature", 32'(signature), 32'(sig));
            check_value("cmd_rdy", 32'(cmd_rdy), 32'd0);
        end
        @(posedge clk);
        done_rdy <= 1'b1;
        @(posedge clk);
        done_rdy <= 1'b0;
        @(negedge clk);
        check_value("done_val", 32'(done_val), 32'd0);
        check_value("cmd_rdy", 32'(cmd_rdy), 32'd1);
    endtask

    task automatic idle_cycles(input int gap);
        @(posedge clk);
        repeat (gap) @(posedge clk);
    endtask

    task automatic load_seed(input logic [W-1:0] s);
        lbist_cmd_word_u w;
        w.seed = s;
        send_cmd(CMD_LOAD_SEED, w);
        model_seed = s;
    endtask

    task automatic run_and_check(input int count, input int stall);
        lbist_cmd_word_u w;
        logic [W-1:0]    sig;
        w.run.reserved = '0;
        w.run.count    = `LBIST_COUNT_BITS'(count);
        send_cmd(CMD_RUN, w);
        collect_result(stall, sig);
        check_value("signature", 32'(sig), 32'(model_signature(model_seed, count)));
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        reset    = 1'b1;
        cmd_val  = 1'b0;
        cmd_op   = CMD_LOAD_SEED;
        cmd_word = '0;
        done_rdy = 1'b0;
        model_seed = W'(1);

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("cmd_rdy", 32'(cmd_rdy), 32'd1);
        check_value("done_val", 32'(done_val), 32'd0);

        // Default seed after reset
        idle_cycles(rand_range(0, 3));
        run_and_check(rand_range(1, 64), rand_range(0, 4));

        // Loaded seed, random length
        idle_cycles(rand_range(0, 5));
        load_seed(rand_word());
        idle_cycles(rand_range(0, 5));
        run_and_check(rand_range(1, 64), 0);

        // Long stall on the result port
        idle_cycles(rand_range(0, 5));
        run_and_check(rand_range(1, 64), rand_range(5, 20));

        // Zero-length run
        idle_cycles(rand_range(0, 5));
        run_and_check(0, rand_range(0, 3));

        // Same seed and N twice, then a new seed
        n = rand_range(1, 64);
        idle_cycles(rand_range(0, 5));
        run_and_check(n, rand_range(0, 4));
        idle_cycles(rand_range(0, 5));
        run_and_check(n, rand_range(0, 4));
        new_seed = rand_word();
        if (new_seed == model_seed) begin
            new_seed = ~new_seed;
        end
        idle_cycles(rand_range(0, 5));
        load_seed(new_seed);
        run_and_check(n, rand_range(0, 4));

        // Random load and run sequences
        for (int i = 0; i < 20; i++) begin
            idle_cycles(rand_range(0, 6));
            if (rand_range(0, 1) == 1) begin
                load_seed(rand_word());
                idle_cycles(rand_range(0, 6));
            end
            run_and_check(rand_range(0, 64), rand_range(0, 6));
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* lbist_top.sv */
// ========================================
// LBIST top level
// Controller, LFSR, CUT and MISR
// ========================================

`default_nettype none

`include "lbist_settings.svh"

module lbist_top
    import lbist_cmd_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_val,
    input  lbist_cmd_op_e           cmd_op,
    input  logic [`LBIST_WIDTH-1:0] cmd_word,
    output logic                    cmd_rdy,
    output logic                    done_val,
    output logic [`LBIST_WIDTH-1:0] signature,
    input  logic                    done_rdy
);

    logic                    seed_val;
    logic [`LBIST_WIDTH-1:0] seed;
    logic                    seed_rdy;
    logic                    lfsr_restart;
    logic                    lfsr_vec_val;
    logic [`LBIST_WIDTH-1:0] lfsr_vec;
    logic                    lfsr_vec_rdy;
    logic                    cut_in_val;
    logic                    cut_in_rdy;
    logic                    rsp_val;
    logic [`LBIST_WIDTH-1:0] rsp;
    logic                    misr_clear;
    logic [`LBIST_WIDTH-1:0] misr_signature;

    lbist_ctrl ctrl_i (
        .clk            (clk),
        .reset          (reset),
        .cmd_val        (cmd_val),
        .cmd_op         (cmd_op),
        .cmd_word       (cmd_word),
        .cmd_rdy        (cmd_rdy),
        .seed_val       (seed_val),
        .seed           (seed),
        .seed_rdy       (seed_rdy),
        .lfsr_restart   (lfsr_restart),
        .lfsr_vec_val   (lfsr_vec_val),
        .lfsr_vec_rdy   (lfsr_vec_rdy),
        .cut_in_val     (cut_in_val),
        .cut_in_rdy     (cut_in_rdy),
        .rsp_val        (rsp_val),
        .misr_clear     (misr_clear),
        .signature      (misr_signature),
        .done_val       (done_val),
        .done_signature (signature),
        .done_rdy       (done_rdy)
    );

    lbist_lfsr lfsr_i (
        .clk      (clk),
        .reset    (reset),
        .restart  (lfsr_restart),
        .req_val  (seed_val),
        .req_msg  (seed),
        .req_rdy  (seed_rdy),
        .resp_val (lfsr_vec_val),
        .resp_msg (lfsr_vec),
        .resp_rdy (lfsr_vec_rdy)
    );

    // MISR never stalls, so the CUT output is always ready
    lbist_cut cut_i (
        .clk      (clk),
        .reset    (reset),
        .in_val   (cut_in_val),
        .in_data  (lfsr_vec),
        .in_rdy   (cut_in_rdy),
        .out_val  (rsp_val),
        .out_data (rsp),
        .out_rdy  (1'b1)
    );

    lbist_misr misr_i (
        .clk       (clk),
        .reset     (reset),
        .clear     (misr_clear),
        .in_val    (rsp_val),
        .in_data   (rsp),
        .signature (misr_signature)
    );

endmodule

`default_nettype wire

/* lbist_ctrl.sv */
// ========================================
// LBIST controller
// Command decode, seed storage, vector and
// response counting, result hand-off
// ========================================

`default_nettype none

`include "lbist_settings.svh"

module lbist_ctrl
    import lbist_cmd_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    // Command port
    input  logic                    cmd_val,
    input  lbist_cmd_op_e           cmd_op,
    input  lbist_cmd_word_u         cmd_word,
    output logic                    cmd_rdy,

    // LFSR seed side
    output logic                    seed_val,
    output logic [`LBIST_WIDTH-1:0] seed,
    input  logic                    seed_rdy,
    output logic                    lfsr_restart,

    // LFSR to CUT handshake gating
    input  logic                    lfsr_vec_val,
    output logic                    lfsr_vec_rdy,
    output logic                    cut_in_val,
    input  logic                    cut_in_rdy,

    // Response side
    input  logic                    rsp_val,
    output logic                    misr_clear,
    input  logic [`LBIST_WIDTH-1:0] signature,

    // Result port
    output logic                    done_val,
    output logic [`LBIST_WIDTH-1:0] done_signature,
    input  logic                    done_rdy
);

    localparam logic [`LBIST_WIDTH-1:0] SEED_RESET = 1;

    lbist_ctrl_state_e            state;
    logic [`LBIST_WIDTH-1:0]      seed_reg;
    logic [`LBIST_COUNT_BITS-1:0] vec_left;
    logic [`LBIST_COUNT_BITS-1:0] rsp_left;
    logic                         start_pulse;
    logic                         cmd_xfer;
    logic                         vec_more;
    logic                         vec_xfer;
    logic                         enter_done;

    // ========================================
    // Handshakes and outputs
    // ========================================
    assign cmd_rdy      = (state == IDLE);
    assign cmd_xfer     = cmd_val && cmd_rdy;
    assign seed_val     = (state == SEED);
    assign seed         = seed_reg;
    assign lfsr_restart = start_pulse;
    assign misr_clear   = start_pulse;
    assign done_val     = (state == DONE);

    // Vector flow stops once N have been issued
    assign vec_more     = (state == STREAM) && (vec_left != '0);
    assign cut_in_val   = lfsr_vec_val && vec_more;
    assign lfsr_vec_rdy = cut_in_rdy && vec_more;
    assign vec_xfer     = lfsr_vec_val && lfsr_vec_rdy;

    // Zero-length run skips straight to the result
    assign enter_done = ((state == SEED) && seed_rdy && (vec_left == '0))
                     || ((state == DRAIN) && (rsp_left == '0));

    // ========================================
    // Sequencer
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            seed_reg    <= SEED_RESET;
            vec_left    <= '0;
            rsp_left    <= '0;
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= 1'b0;
            if (rsp_val && (rsp_left != '0)) begin
                rsp_left <= rsp_left - 1'b1;
            end
            case (state)
                IDLE: begin
                    if (cmd_xfer && (cmd_op == CMD_LOAD_SEED)) begin
                        seed_reg <= cmd_word.seed;
                    end else if (cmd_xfer) begin
                        vec_left    <= cmd_word.run.count;
                        rsp_left    <= cmd_word.run.count;
                        start_pulse <= 1'b1;
                        state       <= SEED;
                    end
                end
                SEED: begin
                    if (enter_done) begin
                        state <= DONE;
                    end else if (seed_rdy) begin
                        state <= STREAM;
                    end
                end
                STREAM: begin
                    if (vec_xfer) begin
                        vec_left <= vec_left - 1'b1;
                        // Last vector issued
                        if (vec_left == 1) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    if (enter_done) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (done_rdy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Final signature captured once all responses are in
    always_ff @(posedge clk) begin
        if (enter_done) begin
            done_signature <= signature;
        end
    end

endmodule

`default_nettype wire

/* lbist_misr.sv */
// ========================================
// LBIST signature register
// MISR folding one response per valid cycle
// ========================================

`default_nettype none

`include "lbist_settings.svh"

module lbist_misr
    import lbist_poly_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clear,
    input  logic                    in_val,
    input  logic [`LBIST_WIDTH-1:0] in_data,
    output logic [`LBIST_WIDTH-1:0] signature
);

    // Same polynomial as the pattern generator
    localparam lbist_tap_mask_t TAPS = lbist_tap_mask(`LBIST_WIDTH);

    logic                    feedback;
    logic [`LBIST_WIDTH-1:0] sig_next;

    assign feedback = ^(signature & TAPS);

    // Shift with feedback, then fold in the response
    assign sig_next = {signature[`LBIST_WIDTH-2:0], feedback} ^ in_data;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            signature <= '0;
        end else if (in_val) begin
            signature <= sig_next;
        end
    end

endmodule

`default_nettype wire

/* lbist_cut.sv */
// ========================================
// LBIST circuit under test
// Two-stage val/rdy mixing pipeline
// ========================================

`default_nettype none

`include "lbist_settings.svh"

module lbist_cut (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_val,
    input  logic [`LBIST_WIDTH-1:0] in_data,
    output logic                    in_rdy,
    output logic                    out_val,
    output logic [`LBIST_WIDTH-1:0] out_data,
    input  logic                    out_rdy
);

    logic                    s1_val;
    logic [`LBIST_WIDTH-1:0] s1_data;
    logic                    s2_val;
    logic [`LBIST_WIDTH-1:0] s2_data;
    logic                    s1_en;
    logic                    s2_en;
    logic [`LBIST_WIDTH-1:0] mix1;
    logic [`LBIST_WIDTH-1:0] s1_rev;

    // Stage one function, input XOR input rotated left by seven
    assign mix1 = in_data ^ ((in_data << 7) | (in_data >> (`LBIST_WIDTH - 7)));

    // Bit reversal of the stage one value
    always_comb begin
        for (int i = 0; i < `LBIST_WIDTH; i++) begin
            s1_rev[i] = s1_data[`LBIST_WIDTH-1-i];
        end
    end

    // A stage loads when its slot is empty or is draining this cycle
    assign s2_en  = !s2_val || out_rdy;
    assign s1_en  = !s1_val || s2_en;
    assign in_rdy = s1_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_val <= 1'b0;
            s2_val <= 1'b0;
        end else begin
            if (s1_en) begin
                s1_val <= in_val;
            end
            if (s2_en) begin
                s2_val <= s1_val;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_en && in_val) begin
            s1_data <= mix1;
        end
        if (s2_en && s1_val) begin
            s2_data <= s1_data + s1_rev;
        end
    end

    assign out_val  = s2_val;
    assign out_data = s2_data;

endmodule

`default_nettype wire

/* lbist_lfsr.sv */
// ========================================
// LBIST pattern generator
// Seeded Fibonacci LFSR with val/rdy ports
// ========================================

`default_nettype none

`include "lbist_settings.svh"

module lbist_lfsr
    import lbist_poly_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    restart,

    // Seed request from the controller
    input  logic                    req_val,
    input  logic [`LBIST_WIDTH-1:0] req_msg,
    output logic                    req_rdy,

    // Vector stream toward the CUT
    output logic                    resp_val,
    output logic [`LBIST_WIDTH-1:0] resp_msg,
    input  logic                    resp_rdy
);

    // ========================================
    // Local constants
    // ========================================
    localparam lbist_tap_mask_t TAPS = lbist_tap_mask(`LBIST_WIDTH);

    // Waiting for a seed, or generating vectors
    localparam logic IDLE    = 1'b0;
    localparam logic GEN_VAL = 1'b1;

    logic                    state;
    logic [`LBIST_WIDTH-1:0] q;
    logic                    feedback;

    // XOR of all tapped bits
    assign feedback = ^(q & TAPS);

    // ========================================
    // State and shift register
    // ========================================
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            state <= IDLE;
            q     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_val) begin
                        q     <= req_msg;
                        state <= GEN_VAL;
                    end
                end
                GEN_VAL: begin
                    // Advance only on an accepted vector
                    if (resp_rdy) begin
                        q <= {q[`LBIST_WIDTH-2:0], feedback};
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // No seed taken while a restart is in progress
    assign req_rdy  = (state == IDLE) && !restart;
    assign resp_val = (state == GEN_VAL);
    assign resp_msg = (state == GEN_VAL) ? q : '0;

endmodule

`default_nettype wire

/* lbist_poly_pkg.sv */
// ========================================
// LBIST polynomial package
// Feedback tap sets for the LFSR and MISR
// ========================================

`default_nettype none

`include "lbist_settings.svh"

package lbist_poly_pkg;

    // One bit set per feedback tap
    typedef logic [`LBIST_WIDTH-1:0] lbist_tap_mask_t;

    // Tap positions per width, two or four taps; -1 marks an unused slot
    function automatic lbist_tap_mask_t lbist_tap_mask(input int width);
        int          t [4];
        logic [31:0] m;
        case (width)
            2:       t = '{0, 1, -1, -1};
            3:       t = '{0, 2, -1, -1};
            4:       t = '{0, 3, -1, -1};
            5:       t = '{1, 4, -1, -1};
            6:       t = '{0, 5, -1, -1};
            7:       t = '{0, 6, -1, -1};
            8:       t = '{1, 2, 3, 7};
            9:       t = '{3, 8, -1, -1};
            10:      t = '{2, 9, -1, -1};
            11:      t = '{1, 10, -1, -1};
            12:      t = '{0, 3, 5, 11};
            13:      t = '{0, 2, 3, 12};
            14:      t = '{0, 2, 4, 13};
            15:      t = '{0, 14, -1, -1};
            16:      t = '{1, 2, 4, 15};
            17:      t = '{2, 16, -1, -1};
            18:      t = '{6, 17, -1, -1};
            19:      t = '{0, 1, 4, 18};
            20:      t = '{2, 19, -1, -1};
            21:      t = '{1, 20, -1, -1};
            22:      t = '{0, 21, -1, -1};
            23:      t = '{4, 22, -1, -1};
            24:      t = '{0, 2, 3, 23};
            25:      t = '{2, 24, -1, -1};
            26:      t = '{0, 1, 5, 25};
            27:      t = '{0, 1, 4, 26};
            28:      t = '{2, 27, -1, -1};
            29:      t = '{1, 28, -1, -1};
            30:      t = '{0, 3, 5, 29};
            31:      t = '{2, 30, -1, -1};
            32:      t = '{1, 5, 6, 31};
            default: t = '{-1, -1, -1, -1};
        endcase
        m = '0;
        for (int i = 0; i < 4; i++) begin
            if (t[i] >= 0) begin
                m[t[i]] = 1'b1;
            end
        end
        return lbist_tap_mask_t'(m);
    endfunction

endpackage

`default_nettype wire

/* lbist_cmd_pkg.sv */
// ========================================
// LBIST command package
// Command opcodes, command word layout and
// controller states
// ========================================

`default_nettype none

`include "lbist_settings.svh"

package lbist_cmd_pkg;

    // Command opcodes
    typedef enum logic {
        CMD_LOAD_SEED = 1'b0,
        CMD_RUN       = 1'b1
    } lbist_cmd_op_e;

    // Run descriptor, vector count in the low bits
    typedef struct packed {
        logic [`LBIST_WIDTH-`LBIST_COUNT_BITS-1:0] reserved;
        logic [`LBIST_COUNT_BITS-1:0]              count;
    } lbist_run_desc_t;

    // One command word, read by opcode
    typedef union packed {
        logic [`LBIST_WIDTH-1:0] seed;
        lbist_run_desc_t         run;
    } lbist_cmd_word_u;

    // Controller sequence
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        SEED   = 3'd1,
        STREAM = 3'd2,
        DRAIN  = 3'd3,
        DONE   = 3'd4
    } lbist_ctrl_state_e;

endpackage

`default_nettype wire

/* lbist_settings.svh */
// ========================================
// LBIST build settings
// Data path width and run counter width
// ========================================

`ifndef LBIST_SETTINGS_SVH
`define LBIST_SETTINGS_SVH

// Width of seed, test vectors, CUT responses and signature.
// Must be a width covered by the tap table (2 to 32).
`define LBIST_WIDTH 32

// Width of the vector count carried by a run command
`define LBIST_COUNT_BITS 16

`endif
